/* src/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ------------------------------------------------------------
// Core sizing
// ------------------------------------------------------------

// Register address width
// MSB of the address picks bank 0 or bank 1
`define CORE_ADDR_WIDTH 6

// Machine word width
`define CORE_DATA_WIDTH 32

// Registers in one bank
// Two banks fill the whole address space
`define CORE_BANK_WORDS 32

`endif

/* src/core_pkg.sv */
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // ------------------------------------------------------------
  // Data and address types
  // ------------------------------------------------------------

  // One machine word
  typedef logic [`CORE_DATA_WIDTH-1:0] word_t;

  // Register address with the bank select in the MSB
  typedef logic [`CORE_ADDR_WIDTH-1:0] reg_addr_t;

  // ADDI immediate before sign extension
  typedef logic [15:0] imm_t;

  // ------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------

  // Codes 10 to 15 are undefined
  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    // Shift amount from the low five bits of rs2
    SLL  = 4'h5,
    SRL  = 4'h6,
    ADDI = 4'h7,
    // Three operand ops use read port C
    ADD3 = 4'h8,
    CMOV = 4'h9   // rs3 != 0 picks rs1
  } alu_op_e;

endpackage

`default_nettype wire

/* src/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  // Instruction strobe
  input  logic                instr_valid_i,
  input  core_pkg::word_t     instr_i,
  // Decoded fields
  output core_pkg::alu_op_e   op_o,
  output core_pkg::reg_addr_t rd_o,
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  output core_pkg::reg_addr_t raddr_c_o,
  output core_pkg::imm_t      imm_o,
  // Status
  output logic                dec_valid_o,
  output logic                undef_o
);

  import core_pkg::*;

  // Raw opcode field
  logic [$bits(alu_op_e)-1:0] opcode;

  // Opcode is one of the defined set
  logic                       op_known;

  // ------------------------------------------------------------
  // Field extraction
  // ------------------------------------------------------------

  // Opcode in the top nibble
  assign opcode    = instr_i[31:28];
  assign op_o      = alu_op_e'(opcode);

  // Destination and three sources
  assign rd_o      = instr_i[27:22];
  assign raddr_a_o = instr_i[21:16];
  assign raddr_b_o = instr_i[15:10];
  assign raddr_c_o = instr_i[9:4];

  // Immediate overlaps rs2 and rs3
  // Only ADDI looks at it
  assign imm_o     = instr_i[15:0];

  // ------------------------------------------------------------
  // Opcode check
  // ------------------------------------------------------------

  always_comb begin
    case (op_o)
      ADD, SUB, AND, OR, XOR,
      SLL, SRL, ADDI, ADD3, CMOV: begin
        op_known = 1'b1;
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  // Only defined opcodes move on to execute
  assign dec_valid_o = instr_valid_i & op_known;

  // Undefined opcode on a live strobe
  assign undef_o     = instr_valid_i & ~op_known;

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module register_file #(
  // Enables bank 1 at the upper half of the address space
  parameter bit SECOND_BANK = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  // Read port A
  input  core_pkg::reg_addr_t raddr_a_i,
  output core_pkg::word_t     rdata_a_o,
  // Read port B
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_b_o,
  // Read port C
  input  core_pkg::reg_addr_t raddr_c_i,
  output core_pkg::word_t     rdata_c_o,
  // Write port A from write-back
  input  core_pkg::reg_addr_t waddr_a_i,
  input  core_pkg::word_t     wdata_a_i,
  input  logic                we_a_i,
  // Write port B from the load path
  input  core_pkg::reg_addr_t waddr_b_i,
  input  core_pkg::word_t     wdata_b_i,
  input  logic                we_b_i
);

  import core_pkg::*;

  // Both banks together
  localparam int NUM_WORDS = 2 * `CORE_BANK_WORDS;

  // Bank 0 in the lower half, bank 1 in the upper half
  word_t mem [NUM_WORDS];

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------

  // Full address indexes both banks directly
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];
  assign rdata_c_o = mem[raddr_c_i];

  // ------------------------------------------------------------
  // Write decode and storage
  // ------------------------------------------------------------

  for (genvar g = 0; g < NUM_WORDS; g++) begin : gen_reg

    // Bank 0 register 0 stays zero
    // Bank 1 exists only with SECOND_BANK set
    localparam bit WRITABLE = (g != 0) && (SECOND_BANK || (g < `CORE_BANK_WORDS));

    logic we_a;
    logic we_b;

    // Per-register enables
    assign we_a = WRITABLE && we_a_i && (waddr_a_i == reg_addr_t'(g));
    assign we_b = WRITABLE && we_b_i && (waddr_b_i == reg_addr_t'(g));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[g] <= '0;
      end else if (we_b) begin
        // Load path wins a same-address collision
        mem[g] <= wdata_b_i;
      end else if (we_a) begin
        mem[g] <= wdata_a_i;
      end
    end

  end

endmodule

`default_nettype wire

/* src/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
  input  logic                clk,
  input  logic                rst_n,
  // Decode status
  input  logic                dec_valid_i,
  input  logic                undef_i,
  // Decoded fields
  input  core_pkg::alu_op_e   op_i,
  input  core_pkg::reg_addr_t rd_i,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  input  core_pkg::reg_addr_t raddr_c_i,
  input  core_pkg::imm_t      imm_i,
  // Register file read data
  input  core_pkg::word_t     rdata_a_i,
  input  core_pkg::word_t     rdata_b_i,
  input  core_pkg::word_t     rdata_c_i,
  // Result register as the older bypass source
  input  logic                wb_valid_i,
  input  core_pkg::reg_addr_t wb_rd_i,
  input  core_pkg::word_t     wb_data_i,
  // Execute stage result
  output logic                ex_valid_o,
  output core_pkg::reg_addr_t ex_rd_o,
  output core_pkg::word_t     ex_result_o,
  output logic                illegal_o
);

  import core_pkg::*;

  // Stage control
  logic      valid_q;
  logic      illegal_q;

  // Stage payload
  alu_op_e   op_q;
  reg_addr_t rd_q;
  imm_t      imm_q;
  word_t     opa_q;
  word_t     opb_q;
  word_t     opc_q;

  // Operands after bypass
  word_t     opnd_a;
  word_t     opnd_b;
  word_t     opnd_c;

  // Live ALU output
  word_t     alu_result;

  // ------------------------------------------------------------
  // Operand bypass
  // ------------------------------------------------------------

  // Youngest producer first, then the result register, then the file
  function automatic word_t fwd(input reg_addr_t addr, input word_t rf_data);
    word_t data;
    data = rf_data;
    // Address 0 never forwards
    if (addr != '0) begin
      if (valid_q && (rd_q == addr)) begin
        data = alu_result;
      end else if (wb_valid_i && (wb_rd_i == addr)) begin
        data = wb_data_i;
      end
    end
    return data;
  endfunction

  always_comb begin
    opnd_a = fwd(raddr_a_i, rdata_a_i);
    opnd_b = fwd(raddr_b_i, rdata_b_i);
    opnd_c = fwd(raddr_c_i, rdata_c_i);
  end

  // ------------------------------------------------------------
  // Stage registers
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= dec_valid_i;
      illegal_q <= undef_i;
    end
  end

  // Payload only moves on a defined instruction
  always_ff @(posedge clk) begin
    if (dec_valid_i) begin
      op_q  <= op_i;
      rd_q  <= rd_i;
      imm_q <= imm_i;
      opa_q <= opnd_a;
      opb_q <= opnd_b;
      opc_q <= opnd_c;
    end
  end

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------

  always_comb begin
    case (op_q)
      ADD:  alu_result = opa_q + opb_q;
      SUB:  alu_result = opa_q - opb_q;
      AND:  alu_result = opa_q & opb_q;
      OR:   alu_result = opa_q | opb_q;
      XOR:  alu_result = opa_q ^ opb_q;
      SLL:  alu_result = opa_q << opb_q[4:0];
      SRL:  alu_result = opa_q >> opb_q[4:0];
      // Sign-extended immediate
      ADDI: alu_result = opa_q + {{($bits(word_t) - $bits(imm_t)){imm_q[$bits(imm_t)-1]}}, imm_q};
      ADD3: alu_result = opa_q + opb_q + opc_q;
      CMOV: alu_result = (opc_q != '0) ? opa_q : opb_q;
      default: alu_result = '0;
    endcase
  end

  assign ex_valid_o  = valid_q;
  assign ex_rd_o     = rd_q;
  assign ex_result_o = alu_result;
  assign illegal_o   = illegal_q;

endmodule

`default_nettype wire

/* src/result_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
  input  logic                clk,
  input  logic                rst_n,
  // Execute stage result
  input  logic                ex_valid_i,
  input  core_pkg::reg_addr_t ex_rd_i,
  input  core_pkg::word_t     ex_result_i,
  // Register file port A and bypass source
  output logic                wb_valid_o,
  output core_pkg::reg_addr_t wb_rd_o,
  output core_pkg::word_t     wb_data_o,
  // Completed instruction report
  output logic                result_valid_o,
  output core_pkg::reg_addr_t result_rd_o,
  output core_pkg::word_t     result_data_o
);

  import core_pkg::*;

  // Committed result held for one cycle
  logic      valid_q;
  reg_addr_t rd_q;
  word_t     data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ex_valid_i;
    end
  end

  // Capture only on a live result
  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      rd_q   <= ex_rd_i;
      data_q <= ex_result_i;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  // rd 0 still writes here and the file drops it
  assign wb_valid_o     = valid_q;
  assign wb_rd_o        = rd_q;
  assign wb_data_o      = data_q;

  assign result_valid_o = valid_q;
  assign result_rd_o    = rd_q;
  assign result_data_o  = data_q;

endmodule

`default_nettype wire

/* src/exec_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_top #(
  // Passed to the register file
  parameter bit SECOND_BANK = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  // Instruction strobe
  input  logic                instr_valid_i,
  input  core_pkg::word_t     instr_i,
  // Direct register load
  input  logic                load_valid_i,
  input  core_pkg::reg_addr_t load_addr_i,
  input  core_pkg::word_t     load_data_i,
  // Completed results
  output logic                result_valid_o,
  output core_pkg::reg_addr_t result_rd_o,
  output core_pkg::word_t     result_data_o,
  output logic                illegal_o
);

  import core_pkg::*;

  // Decode outputs
  logic      dec_valid;
  logic      dec_undef;
  alu_op_e   dec_op;
  reg_addr_t dec_rd;
  reg_addr_t dec_raddr_a;
  reg_addr_t dec_raddr_b;
  reg_addr_t dec_raddr_c;
  imm_t      dec_imm;

  // Register file read data
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  word_t     rf_rdata_c;

  // Execute stage
  logic      ex_valid;
  reg_addr_t ex_rd;
  word_t     ex_result;

  // Result register
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;

  // ------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------

  instr_decode instr_decode_inst (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .op_o          (dec_op),
    .rd_o          (dec_rd),
    .raddr_a_o     (dec_raddr_a),
    .raddr_b_o     (dec_raddr_b),
    .raddr_c_o     (dec_raddr_c),
    .imm_o         (dec_imm),
    .dec_valid_o   (dec_valid),
    .undef_o       (dec_undef)
  );

  // Port A takes write-back and port B takes loads
  register_file #(
    .SECOND_BANK (SECOND_BANK)
  ) register_file_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (dec_raddr_a),
    .rdata_a_o (rf_rdata_a),
    .raddr_b_i (dec_raddr_b),
    .rdata_b_o (rf_rdata_b),
    .raddr_c_i (dec_raddr_c),
    .rdata_c_o (rf_rdata_c),
    .waddr_a_i (wb_rd),
    .wdata_a_i (wb_data),
    .we_a_i    (wb_valid),
    .waddr_b_i (load_addr_i),
    .wdata_b_i (load_data_i),
    .we_b_i    (load_valid_i)
  );

  alu_execute alu_execute_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid_i (dec_valid),
    .undef_i     (dec_undef),
    .op_i        (dec_op),
    .rd_i        (dec_rd),
    .raddr_a_i   (dec_raddr_a),
    .raddr_b_i   (dec_raddr_b),
    .raddr_c_i   (dec_raddr_c),
    .imm_i       (dec_imm),
    .rdata_a_i   (rf_rdata_a),
    .rdata_b_i   (rf_rdata_b),
    .rdata_c_i   (rf_rdata_c),
    .wb_valid_i  (wb_valid),
    .wb_rd_i     (wb_rd),
    .wb_data_i   (wb_data),
    .ex_valid_o  (ex_valid),
    .ex_rd_o     (ex_rd),
    .ex_result_o (ex_result),
    .illegal_o   (illegal_o)
  );

  result_writeback result_writeback_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid),
    .ex_rd_i        (ex_rd),
    .ex_result_i    (ex_result),
    .wb_valid_o     (wb_valid),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

`default_nettype wire

/* bench/exec_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_assert (
  input logic            clk,
  input logic            rst_n,
  input logic            instr_valid_i,
  input core_pkg::word_t instr_i,
  input logic            result_valid_o,
  input logic            illegal_o
);

  import core_pkg::*;

  // Strobe carrying a defined opcode
  logic defined_strobe;

  assign defined_strobe = instr_valid_i && (instr_i[31:28] <= CMOV);

  // ------------------------------------------------------------
  // Output rules
  // ------------------------------------------------------------

  // Quiet outputs while reset is held
  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!illegal_o && !result_valid_o))
    else $error("illegal_o or result_valid_o high during reset");

  // Two cycles from defined strobe to result and back
  result_latency: assert property (@(posedge clk) disable iff (!rst_n)
    defined_strobe |-> ##2 result_valid_o)
    else $error("result_valid_o missing two cycles after a defined instruction");

  result_source: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |-> $past(defined_strobe, 2))
    else $error("result_valid_o without a defined instruction two cycles before");

  // Undefined instruction never completes
  no_result_after_illegal: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_o |=> !result_valid_o)
    else $error("result reported for an undefined instruction");

endmodule

bind exec_core_top exec_core_assert exec_core_assert_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .instr_valid_i  (instr_valid_i),
  .instr_i        (instr_i),
  .result_valid_o (result_valid_o),
  .illegal_o      (illegal_o)
);

`default_nettype wire

/* bench/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module exec_core_tb;

  import core_pkg::*;

  // Upper bounds on each test in cycles
  localparam int LOAD_LEN    = 40;
  localparam int ALU_LEN     = 185;
  localparam int BYPASS_LEN  = 25;
  localparam int THREE_LEN   = 20;
  localparam int UNDEF_LEN   = 45;
  localparam int PRIO_LEN    = 20;
  localparam int CYCLE_LIMIT =
    2 * (LOAD_LEN + ALU_LEN + BYPASS_LEN + THREE_LEN + UNDEF_LEN + PRIO_LEN) + 100;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  word_t     instr_i;
  logic      load_valid_i;
  reg_addr_t load_addr_i;
  word_t     load_data_i;
  logic      result_valid_o;
  reg_addr_t result_rd_o;
  word_t     result_data_o;
  logic      illegal_o;

  // Reference register model over both banks
  word_t     model [2*`CORE_BANK_WORDS];

  // Expected results by issue age
  // Entry 0 was issued one edge back and entry 1 two edges back
  logic      exp_res  [2];
  reg_addr_t exp_rd   [2];
  word_t     exp_data [2];
  logic      exp_ill;

  int        errors;
  int        checks;
  int        cycles = 0;

  exec_core_top #(
    .SECOND_BANK (1'b1)
  ) exec_core_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .load_valid_i   (load_valid_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .illegal_o      (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t expected,
                            input reg_addr_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------
  // Instruction encoding and reference ALU
  // ------------------------------------------------------------

  function automatic word_t encode(input alu_op_e op, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2,
                                   input reg_addr_t rs3);
    return {op, rd, rs1, rs2, rs3, 4'h0};
  endfunction

  // Immediate sits over rs2 and rs3
  function automatic word_t encode_imm(input alu_op_e op, input reg_addr_t rd,
                                       input reg_addr_t rs1, input imm_t imm);
    return {op, rd, rs1, imm};
  endfunction

  function automatic word_t expected_result(input alu_op_e op, input word_t a,
                                            input word_t b, input word_t c,
                                            input imm_t imm);
    word_t sext;
    sext = {{16{imm[15]}}, imm};
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      ADDI:    return a + sext;
      ADD3:    return a + b + c;
      CMOV:    return (c != 32'h0) ? a : b;
      default: return 32'h0;
    endcase
  endfunction

  function automatic word_t rand_word();
    return $urandom();
  endfunction

  // ------------------------------------------------------------
  // One cycle of stimulus and checking
  // ------------------------------------------------------------

  task automatic step(input logic iv, input word_t instr, input logic lv,
                      input reg_addr_t la, input word_t ld);
    reg_addr_t rd;
    word_t     res;
    logic      defined;
    @(negedge clk);
    // Illegal flag of the instruction one edge back
    check_flag("illegal_o", exp_ill, illegal_o);
    // Result of the instruction two edges back
    if (exp_res[1] && result_valid_o !== 1'b1) begin
      errors++;
      $display("Error at %0t: result_valid_o stayed low where a result was expected", $time);
    end else if (!exp_res[1] && result_valid_o !== 1'b0) begin
      errors++;
      $display("Error at %0t: result_valid_o went high with no result pending", $time);
    end else if (exp_res[1]) begin
      check_addr("result_rd_o", exp_rd[1], result_rd_o);
      check_word("result_data_o", exp_data[1], result_data_o);
    end
    exp_res[1]    = exp_res[0];
    exp_rd[1]     = exp_rd[0];
    exp_data[1]   = exp_data[0];
    instr_valid_i = iv;
    instr_i       = instr;
    load_valid_i  = lv;
    load_addr_i   = la;
    load_data_i   = ld;
    // Model applies instructions in issue order
    rd          = instr[27:22];
    defined     = (instr[31:28] <= 4'h9);
    res         = expected_result(alu_op_e'(instr[31:28]), model[instr[21:16]],
                                  model[instr[15:10]], model[instr[9:4]], instr[15:0]);
    exp_res[0]  = iv && defined;
    exp_ill     = iv && !defined;
    exp_rd[0]   = rd;
    exp_data[0] = res;
    if (lv && la != 6'd0) begin
      model[la] = ld;
    end
    if (iv && defined && rd != 6'd0) begin
      model[rd] = res;
    end
  endtask

  task automatic issue(input word_t instr);
    step(1'b1, instr, 1'b0, 6'd0, 32'h0);
  endtask

  task automatic load_reg(input reg_addr_t addr, input word_t data);
    step(1'b0, 32'h0, 1'b1, addr, data);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 32'h0, 1'b0, 6'd0, 32'h0);
  endtask

  // OR with register 0 into rd 0 reports the register value
  task automatic read_back(input reg_addr_t addr);
    issue(encode(OR, 6'd0, addr, 6'd0, 6'd0));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_load_readback();
    // Every fourth address hits both 0 and 32
    for (int i = 0; i < 16; i++) begin
      load_reg(reg_addr_t'(i * 4), rand_word());
    end
    idle(1);
    for (int i = 0; i < 16; i++) begin
      read_back(reg_addr_t'(i * 4));
    end
    idle(3);
  endtask

  task automatic test_alu_ops();
    reg_addr_t rd;
    imm_t      imm;
    for (int round = 0; round < 3; round++) begin
      for (int op = 0; op < 10; op++) begin
        load_reg(6'd5, rand_word());
        // Shift amounts above 31
        load_reg(6'd6, rand_word() | 32'h20);
        load_reg(6'd37, rand_word());
        rd  = reg_addr_t'(8 + op + ((round == 1) ? 32 : 0));
        imm = imm_t'(rand_word());
        // Negative immediates in rounds 0 and 2
        if (round != 1) begin
          imm[15] = 1'b1;
        end
        if (op == 7) begin
          issue(encode_imm(ADDI, rd, 6'd5, imm));
        end else begin
          issue(encode(alu_op_e'(op[3:0]), rd, 6'd5, 6'd6, 6'd37));
        end
        idle(2);
      end
    end
    idle(3);
  endtask

  task automatic test_bypass();
    load_reg(6'd1, rand_word());
    load_reg(6'd2, rand_word());
    load_reg(6'd33, rand_word());
    idle(1);
    // r10 used at distance one, two and three
    issue(encode(ADD, 6'd10, 6'd1, 6'd2, 6'd0));
    issue(encode(SUB, 6'd11, 6'd10, 6'd1, 6'd0));
    issue(encode(XOR, 6'd12, 6'd10, 6'd11, 6'd0));
    issue(encode(ADD, 6'd13, 6'd10, 6'd12, 6'd0));
    // Chain through bank 1
    issue(encode(ADD, 6'd40, 6'd33, 6'd13, 6'd0));
    issue(encode(SLL, 6'd41, 6'd40, 6'd2, 6'd0));
    issue(encode(OR, 6'd42, 6'd41, 6'd40, 6'd0));
    // Youngest of two writes to r10 in flight wins
    issue(encode(ADD, 6'd10, 6'd1, 6'd1, 6'd0));
    issue(encode(ADD, 6'd10, 6'd2, 6'd2, 6'd0));
    issue(encode(OR, 6'd0, 6'd10, 6'd0, 6'd0));
    issue(encode(AND, 6'd14, 6'd10, 6'd10, 6'd0));
    idle(3);
  endtask

  task automatic test_three_operand();
    load_reg(6'd20, rand_word());
    load_reg(6'd21, rand_word());
    load_reg(6'd22, rand_word() | 32'h100);
    load_reg(6'd23, 32'h0);
    idle(1);
    issue(encode(ADD3, 6'd24, 6'd20, 6'd21, 6'd22));
    issue(encode(CMOV, 6'd25, 6'd20, 6'd21, 6'd22));
    issue(encode(CMOV, 6'd26, 6'd20, 6'd21, 6'd23));
    // rs3 through the execute bypass
    issue(encode(CMOV, 6'd27, 6'd21, 6'd20, 6'd26));
    // One operand from each of the file, the result register and execute
    issue(encode(ADD3, 6'd28, 6'd25, 6'd26, 6'd27));
    // rs3 of register 0
    issue(encode(CMOV, 6'd29, 6'd20, 6'd21, 6'd0));
    idle(3);
  endtask

  task automatic test_undefined_rd0();
    load_reg(6'd15, rand_word());
    load_reg(6'd47, rand_word());
    idle(1);
    for (int code = 10; code < 16; code++) begin
      issue(encode(alu_op_e'(code[3:0]), (code % 2 == 0) ? 6'd15 : 6'd47,
                   6'd1, 6'd2, 6'd3));
      // A defined instruction right behind it
      issue(encode(ADD, 6'd16, 6'd1, 6'd2, 6'd0));
      idle(2);
      read_back((code % 2 == 0) ? 6'd15 : 6'd47);
    end
    issue(encode(ADD, 6'd0, 6'd1, 6'd2, 6'd0));
    idle(2);
    read_back(6'd0);
    idle(3);
  endtask

  task automatic test_load_priority();
    load_reg(6'd15, rand_word());
    load_reg(6'd50, rand_word());
    idle(1);
    issue(encode(ADD, 6'd15, 6'd1, 6'd2, 6'd0));
    issue(encode(XOR, 6'd50, 6'd1, 6'd2, 6'd0));
    // Each load lands in the write-back cycle of the matching instruction
    load_reg(6'd15, rand_word());
    load_reg(6'd50, rand_word());
    idle(2);
    read_back(6'd15);
    read_back(6'd50);
    idle(3);
  endtask

  // ------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h4de0));
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = 32'h0;
    load_valid_i  = 1'b0;
    load_addr_i   = 6'd0;
    load_data_i   = 32'h0;
    errors        = 0;
    checks        = 0;
    exp_ill       = 1'b0;
    for (int i = 0; i < 2; i++) begin
      exp_res[i]  = 1'b0;
      exp_rd[i]   = 6'd0;
      exp_data[i] = 32'h0;
    end
    for (int i = 0; i < 2 * `CORE_BANK_WORDS; i++) begin
      model[i] = 32'h0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_load_readback();
    test_alu_ops();
    test_bypass();
    test_three_operand();
    test_undefined_rd0();
    test_load_priority();

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/core_pkg.sv
src/instr_decode.sv
src/register_file.sv
src/alu_execute.sv
src/result_writeback.sv
src/exec_core_top.sv
bench/exec_core_assert.sv
bench/exec_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execution slice testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_core_tb -f list.f -o exec_core_sim

./obj_dir/exec_core_sim | tee "$LOG"

# Verdict comes from the log
if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi
echo "Simulation run complete, see $LOG"
